//--- Bender.yml
package:
  name: ossc_video_out

sources:
  - files:
      - logic/video_out_pkg.sv
      - logic/out_sync_pipe.sv
      - logic/color_channel.sv
      - logic/dac_sync_encoder.sv
      - logic/ossc_video_out.sv
  - target: test
    files:
      - test/ossc_video_out_tb.sv

//--- logic/color_channel.sv
// One color channel of the output path
// Overlay substitution, HDMI transmitter register and the DAC pipeline
module color_channel #(
    parameter int PIXEL_W = 8
) (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  video_out_pkg::pixel_t pix_i,
    input  logic                  osd_enable_i,
    input  logic                  osd_bit_i,
    input  logic                  dac_en_i,
    output video_out_pkg::pixel_t hdmi_pix_o,
    output video_out_pkg::pixel_t dac_pix_o
);

    video_out_pkg::pixel_t pix_s1;
    video_out_pkg::pixel_t dac_pre;

    // Overlay bit drives the full channel
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_s1 <= '0;
        end else if (osd_enable_i) begin
            pix_s1 <= {PIXEL_W{osd_bit_i}};
        end else begin
            pix_s1 <= pix_i;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_pix_o <= '0;
        end else begin
            hdmi_pix_o <= pix_s1;
        end
    end

    // DAC registers hold while the expansion port is used otherwise
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            dac_pre   <= '0;
            dac_pix_o <= '0;
        end else if (dac_en_i) begin
            dac_pre   <= pix_s1;
            dac_pix_o <= dac_pre;
        end
    end

endmodule

//--- logic/dac_sync_encoder.sv
// Sync encoder for the extra analog output
// Builds HS, VS, BLANK_N and SYNC_N per mode and packs the channel samples
module dac_sync_encoder (
    input  logic                         pclk_out,
    input  logic                         po_reset_n,
    input  logic                         hsync_i,
    input  logic                         vsync_i,
    input  logic                         de_i,
    input  logic                         dac_en_i,
    input  video_out_pkg::extra_out_mode_t mode_i,
    input  video_out_pkg::pixel_t        r_i,
    input  video_out_pkg::pixel_t        g_i,
    input  video_out_pkg::pixel_t        b_i,
    output video_out_pkg::rgb_t          vga_pix_o,
    output logic                         vga_hs_o,
    output logic                         vga_vs_o,
    output logic                         vga_blank_n_o,
    output logic                         vga_sync_n_o
);

    logic csync;
    logic mode_hv;
    logic hs_pre;
    logic vs_pre;
    logic blank_n_pre;
    logic sync_n_pre;

    // Composite sync, active low
    assign csync = ~(hsync_i ^ vsync_i);
    assign mode_hv = (mode_i == video_out_pkg::EXTRA_OUT_RGBHV);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hs_pre      <= 1'b0;
            vs_pre      <= 1'b0;
            blank_n_pre <= 1'b0;
            sync_n_pre  <= 1'b0;
        end else if (dac_en_i) begin
            hs_pre      <= mode_hv ? hsync_i : csync;
            vs_pre      <= mode_hv ? vsync_i : 1'b1;
            blank_n_pre <= (mode_i == video_out_pkg::EXTRA_OUT_YPBPR) ? 1'b1 : de_i;
            // Sync carried on the video signal
            sync_n_pre  <= ((mode_i == video_out_pkg::EXTRA_OUT_RGSB) ||
                            (mode_i == video_out_pkg::EXTRA_OUT_YPBPR)) ? csync : 1'b0;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (dac_en_i) begin
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

    assign vga_pix_o[video_out_pkg::CH_R] = r_i;
    assign vga_pix_o[video_out_pkg::CH_G] = g_i;
    assign vga_pix_o[video_out_pkg::CH_B] = b_i;

endmodule

//--- logic/ossc_video_out.sv
// Output pixel path of the scan converter
// OSD overlay, HDMI transmitter outputs and extra analog DAC output
module ossc_video_out #(
    parameter int PIXEL_W = 8
) (
    input  logic                           pclk_out,
    input  logic                           po_reset_n,
    input  video_out_pkg::rgb_t            sc_pix_i,
    input  logic                           sc_hsync_i,
    input  logic                           sc_vsync_i,
    input  logic                           sc_de_i,
    input  logic                           osd_enable_i,
    input  video_out_pkg::osd_color_t      osd_color_i,
    input  video_out_pkg::exp_sel_t        exp_sel_i,
    input  video_out_pkg::extra_out_mode_t extra_out_mode_i,
    output video_out_pkg::rgb_t            hdmitx_pix_o,
    output logic                           hdmitx_hsync_o,
    output logic                           hdmitx_vsync_o,
    output logic                           hdmitx_de_o,
    output video_out_pkg::rgb_t            vga_pix_o,
    output logic                           vga_hs_o,
    output logic                           vga_vs_o,
    output logic                           vga_blank_n_o,
    output logic                           vga_sync_n_o,
    output logic                           vga_oe_o
);

    logic hsync_s1;
    logic vsync_s1;
    logic de_s1;
    logic dac_en;
    video_out_pkg::rgb_t dac_pix;

    out_sync_pipe u_out_sync_pipe (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .hsync_i      (sc_hsync_i),
        .vsync_i      (sc_vsync_i),
        .de_i         (sc_de_i),
        .exp_sel_i    (exp_sel_i),
        .hsync_s1_o   (hsync_s1),
        .vsync_s1_o   (vsync_s1),
        .de_s1_o      (de_s1),
        .hdmi_hsync_o (hdmitx_hsync_o),
        .hdmi_vsync_o (hdmitx_vsync_o),
        .hdmi_de_o    (hdmitx_de_o),
        .dac_en_o     (dac_en)
    );

    // One slice per color, overlay bit taken from the matching position
    for (genvar ch = 0; ch < video_out_pkg::NUM_COLORS; ch++) begin : g_channel
        color_channel #(
            .PIXEL_W (PIXEL_W)
        ) u_color_channel (
            .pclk_out     (pclk_out),
            .po_reset_n   (po_reset_n),
            .pix_i        (sc_pix_i[ch]),
            .osd_enable_i (osd_enable_i),
            .osd_bit_i    (osd_color_i[ch]),
            .dac_en_i     (dac_en),
            .hdmi_pix_o   (hdmitx_pix_o[ch]),
            .dac_pix_o    (dac_pix[ch])
        );
    end

    dac_sync_encoder u_dac_sync_encoder (
        .pclk_out      (pclk_out),
        .po_reset_n    (po_reset_n),
        .hsync_i       (hsync_s1),
        .vsync_i       (vsync_s1),
        .de_i          (de_s1),
        .dac_en_i      (dac_en),
        .mode_i        (extra_out_mode_i),
        .r_i           (dac_pix[video_out_pkg::CH_R]),
        .g_i           (dac_pix[video_out_pkg::CH_G]),
        .b_i           (dac_pix[video_out_pkg::CH_B]),
        .vga_pix_o     (vga_pix_o),
        .vga_hs_o      (vga_hs_o),
        .vga_vs_o      (vga_vs_o),
        .vga_blank_n_o (vga_blank_n_o),
        .vga_sync_n_o  (vga_sync_n_o)
    );

    // Expansion port driven only in extra output mode
    assign vga_oe_o = dac_en;

endmodule

//--- logic/out_sync_pipe.sv
// Sync and data-enable pipeline for the output and HDMI transmitter stages
// Also decodes whether the expansion port carries the extra analog output
module out_sync_pipe (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic                  de_i,
    input  video_out_pkg::exp_sel_t exp_sel_i,
    output logic                  hsync_s1_o,
    output logic                  vsync_s1_o,
    output logic                  de_s1_o,
    output logic                  hdmi_hsync_o,
    output logic                  hdmi_vsync_o,
    output logic                  hdmi_de_o,
    output logic                  dac_en_o
);

    // Output stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hsync_s1_o <= 1'b0;
            vsync_s1_o <= 1'b0;
            de_s1_o    <= 1'b0;
        end else begin
            hsync_s1_o <= hsync_i;
            vsync_s1_o <= vsync_i;
            de_s1_o    <= de_i;
        end
    end

    // Transmitter stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_hsync_o <= 1'b0;
            hdmi_vsync_o <= 1'b0;
            hdmi_de_o    <= 1'b0;
        end else begin
            hdmi_hsync_o <= hsync_s1_o;
            hdmi_vsync_o <= vsync_s1_o;
            hdmi_de_o    <= de_s1_o;
        end
    end

    // Quasi-static firmware setting, used unregistered
    assign dac_en_o = (exp_sel_i == video_out_pkg::EXP_SEL_EXTRA_OUT);

endmodule

//--- logic/video_out_pkg.sv
// Output pixel path types and control codes
// Shared by the output stages, the color channels and the DAC encoder
package video_out_pkg;

    localparam int NUM_COLORS = 3;

    // Channel order matches the bit order of the overlay color
    localparam int CH_R = 2;
    localparam int CH_G = 1;
    localparam int CH_B = 0;

    typedef logic [7:0] pixel_t;
    typedef pixel_t [NUM_COLORS-1:0] rgb_t;
    typedef logic [NUM_COLORS-1:0] osd_color_t;

    // Expansion port selection
    typedef logic [1:0] exp_sel_t;

    localparam exp_sel_t EXP_SEL_OFF       = 2'd0;
    localparam exp_sel_t EXP_SEL_EXTRA_OUT = 2'd1;
    localparam exp_sel_t EXP_SEL_LEGACY_IN = 2'd2;
    localparam exp_sel_t EXP_SEL_UVC_BDG   = 2'd3;

    // Analog output sync format
    typedef logic [1:0] extra_out_mode_t;

    localparam extra_out_mode_t EXTRA_OUT_RGBHV = 2'd0;
    localparam extra_out_mode_t EXTRA_OUT_RGBCS = 2'd1;
    localparam extra_out_mode_t EXTRA_OUT_RGSB  = 2'd2;
    localparam extra_out_mode_t EXTRA_OUT_YPBPR = 2'd3;

endpackage

//--- ossc_video_out.f
logic/video_out_pkg.sv
logic/out_sync_pipe.sv
logic/color_channel.sv
logic/dac_sync_encoder.sv
logic/ossc_video_out.sv
test/ossc_video_out_tb.sv

//--- test/ossc_video_out_tb.sv
// Testbench for the output pixel path
// Replays vectors from a data file and checks the HDMI and DAC outputs
module ossc_video_out_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VEC      = 32;
    localparam int NUM_FIELDS   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int HDMI_LAT     = 2;
    localparam int DAC_LAT      = 3;
    localparam int CYCLE_LIMIT  = NUM_VEC + RESET_CYCLES + 8;

    // Word positions within one vector line
    localparam int F_PIX       = 0;
    localparam int F_SYNC      = 1;
    localparam int F_CTRL      = 2;
    localparam int F_HDMI_PIX  = 3;
    localparam int F_HDMI_SYNC = 4;
    localparam int F_VGA_PIX   = 5;
    localparam int F_VGA_SYNC  = 6;
    localparam int F_OE        = 7;

    logic                           pclk_out = 1'b0;
    logic                           po_reset_n;
    video_out_pkg::rgb_t            sc_pix_i;
    logic                           sc_hsync_i;
    logic                           sc_vsync_i;
    logic                           sc_de_i;
    logic                           osd_enable_i;
    video_out_pkg::osd_color_t      osd_color_i;
    video_out_pkg::exp_sel_t        exp_sel_i;
    video_out_pkg::extra_out_mode_t extra_out_mode_i;
    video_out_pkg::rgb_t            hdmitx_pix_o;
    logic                           hdmitx_hsync_o;
    logic                           hdmitx_vsync_o;
    logic                           hdmitx_de_o;
    video_out_pkg::rgb_t            vga_pix_o;
    logic                           vga_hs_o;
    logic                           vga_vs_o;
    logic                           vga_blank_n_o;
    logic                           vga_sync_n_o;
    logic                           vga_oe_o;

    logic [23:0] vec_mem [0:NUM_VEC*NUM_FIELDS-1];
    // Vector indices waiting for their result, -1 marks the reset state
    int hdmi_q[$];
    int dac_q[$];
    int cycle_count = 0;

    ossc_video_out #(
        .PIXEL_W (8)
    ) u_ossc_video_out (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .sc_pix_i         (sc_pix_i),
        .sc_hsync_i       (sc_hsync_i),
        .sc_vsync_i       (sc_vsync_i),
        .sc_de_i          (sc_de_i),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .hdmitx_pix_o     (hdmitx_pix_o),
        .hdmitx_hsync_o   (hdmitx_hsync_o),
        .hdmitx_vsync_o   (hdmitx_vsync_o),
        .hdmitx_de_o      (hdmitx_de_o),
        .vga_pix_o        (vga_pix_o),
        .vga_hs_o         (vga_hs_o),
        .vga_vs_o         (vga_vs_o),
        .vga_blank_n_o    (vga_blank_n_o),
        .vga_sync_n_o     (vga_sync_n_o),
        .vga_oe_o         (vga_oe_o)
    );

    always #20 pclk_out = ~pclk_out;

    always @(posedge pclk_out) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [23:0] field(input int idx, input int pos);
        return vec_mem[idx*NUM_FIELDS + pos];
    endfunction

    task automatic check_pix(input string name, input video_out_pkg::rgb_t exp_val,
                             input video_out_pkg::rgb_t act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp_val, act_val);
            $display("Checks failed");
            $fatal(1, "Pixel mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp_val, act_val);
            $display("Checks failed");
            $fatal(1, "Bit mismatch");
        end
    endtask

    // Sync and control words carry one field per hex digit
    task automatic drive_vector(input int idx);
        logic [23:0] sync_w;
        logic [23:0] ctrl_w;
        sync_w = field(idx, F_SYNC);
        ctrl_w = field(idx, F_CTRL);
        sc_pix_i         <= field(idx, F_PIX);
        sc_hsync_i       <= sync_w[8];
        sc_vsync_i       <= sync_w[4];
        sc_de_i          <= sync_w[0];
        osd_enable_i     <= ctrl_w[12];
        osd_color_i      <= ctrl_w[10:8];
        exp_sel_i        <= ctrl_w[5:4];
        extra_out_mode_i <= ctrl_w[1:0];
    endtask

    task automatic check_hdmi(input int idx);
        string tag;
        video_out_pkg::rgb_t exp_pix;
        logic [23:0] exp_sync;
        if (idx < 0) begin
            tag      = "hdmi after reset";
            exp_pix  = '0;
            exp_sync = '0;
        end else begin
            tag      = $sformatf("vector %0d hdmi", idx);
            exp_pix  = field(idx, F_HDMI_PIX);
            exp_sync = field(idx, F_HDMI_SYNC);
        end
        check_pix({tag, " pix"}, exp_pix, hdmitx_pix_o);
        check_bit({tag, " hsync"}, exp_sync[8], hdmitx_hsync_o);
        check_bit({tag, " vsync"}, exp_sync[4], hdmitx_vsync_o);
        check_bit({tag, " de"}, exp_sync[0], hdmitx_de_o);
    endtask

    task automatic check_dac(input int idx);
        string tag;
        video_out_pkg::rgb_t exp_pix;
        logic [23:0] exp_sync;
        if (idx < 0) begin
            tag      = "dac after reset";
            exp_pix  = '0;
            exp_sync = '0;
        end else begin
            tag      = $sformatf("vector %0d dac", idx);
            exp_pix  = field(idx, F_VGA_PIX);
            exp_sync = field(idx, F_VGA_SYNC);
        end
        check_pix({tag, " pix"}, exp_pix, vga_pix_o);
        check_bit({tag, " hs"}, exp_sync[12], vga_hs_o);
        check_bit({tag, " vs"}, exp_sync[8], vga_vs_o);
        check_bit({tag, " blank_n"}, exp_sync[4], vga_blank_n_o);
        check_bit({tag, " sync_n"}, exp_sync[0], vga_sync_n_o);
    endtask

    initial begin
        int idx;
        logic [23:0] oe_w;
        po_reset_n       = 1'b0;
        sc_pix_i         = '0;
        sc_hsync_i       = 1'b0;
        sc_vsync_i       = 1'b0;
        sc_de_i          = 1'b0;
        osd_enable_i     = 1'b0;
        osd_color_i      = '0;
        exp_sel_i        = video_out_pkg::EXP_SEL_OFF;
        extra_out_mode_i = video_out_pkg::EXTRA_OUT_RGBHV;
        $readmemh("test/video_out_input.txt", vec_mem);
        if ($isunknown(vec_mem[NUM_VEC*NUM_FIELDS-1])) begin
            $display("Vector file is missing or shorter than expected");
            $display("Checks failed");
            $fatal(1, "Bad vector file");
        end
        repeat (HDMI_LAT) hdmi_q.push_back(-1);
        repeat (DAC_LAT) dac_q.push_back(-1);
        repeat (RESET_CYCLES - 1) @(posedge pclk_out);
        @(negedge pclk_out);
        // Output registers still held in reset
        check_hdmi(-1);
        check_dac(-1);
        @(posedge pclk_out);
        po_reset_n <= 1'b1;
        // Trailing cycles hold the last vector while the pipeline drains
        for (int n = 0; n < NUM_VEC + DAC_LAT; n++) begin
            @(posedge pclk_out);
            if (n < NUM_VEC) begin
                drive_vector(n);
            end
            hdmi_q.push_back(n);
            dac_q.push_back(n);
            @(negedge pclk_out);
            if (n < NUM_VEC) begin
                oe_w = field(n, F_OE);
                check_bit($sformatf("vector %0d vga_oe", n), oe_w[0], vga_oe_o);
            end
            idx = hdmi_q.pop_front();
            if (idx < NUM_VEC) begin
                check_hdmi(idx);
            end
            idx = dac_q.pop_front();
            if (idx < NUM_VEC) begin
                check_dac(idx);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- test/video_out_input.txt
// Columns: pixel, sync in (h v de), control (osd_en osd_color exp_sel mode),
// expected hdmi pixel, hdmi sync (h v de), vga pixel, vga sync (hs vs blank_n sync_n), vga_oe
// Hex words; each digit of a sync or control word is one field
// DAC sync of a vector uses the mode of the following vector
102030 001 0010 102030 001 102030 0010 1
405060 101 0010 405060 101 405060 1010 1
a1b2c3 011 0010 a1b2c3 011 a1b2c3 0110 1
0f1e2d 110 0010 0f1e2d 110 0f1e2d 1100 1
fedcba 000 0010 fedcba 000 fedcba 0000 1
123456 101 0010 123456 101 123456 1010 1
111111 001 1510 ff00ff 001 ff00ff 0010 1
222222 110 1210 00ff00 110 00ff00 1100 1
333333 011 1710 ffffff 011 ffffff 0110 1
444444 101 1010 000000 101 000000 0110 1
556677 001 0011 556677 001 556677 1110 1
8899aa 101 0011 8899aa 101 8899aa 0110 1
bbccdd 011 0011 bbccdd 011 bbccdd 0110 1
eeff00 110 0011 eeff00 110 eeff00 1100 1
13579b 000 0011 13579b 000 13579b 1101 1
2468ac 001 0012 2468ac 001 2468ac 1111 1
369cf0 101 0012 369cf0 101 369cf0 0110 1
48c048 011 1412 ff0000 011 ff0000 0110 1
5a5a5a 110 0012 5a5a5a 110 5a5a5a 1101 1
a5a5a5 000 0012 a5a5a5 000 a5a5a5 1111 1
0a0b0c 001 0013 0a0b0c 001 0a0b0c 1111 1
1a1b1c 101 0013 1a1b1c 101 1a1b1c 0110 1
2a2b2c 011 0013 2a2b2c 011 2a2b2c 0110 1
3a3b3c 110 1313 00ffff 110 2a2b2c 0110 1
4a4b4c 000 0013 4a4b4c 000 2a2b2c 0110 1
5a6b7c 101 0003 5a6b7c 101 2a2b2c 0110 0
6a7b8c 011 0023 6a7b8c 011 2a2b2c 0110 0
7a8b9c 001 0033 7a8b9c 001 2a2b2c 0110 0
8a9bac 110 1600 ffff00 110 2a2b2c 0110 0
9aabbc 001 0020 9aabbc 001 2a2b2c 0110 0
aabbcc 101 0000 aabbcc 101 2a2b2c 0110 0
bbccdd 000 0000 bbccdd 000 2a2b2c 0110 0
